// ==== hdl/ln_pkg.sv ====
`default_nettype none

package ln_pkg;

    // one input sample
    localparam int LANE_WIDTH = 8;
    // one squared sample
    localparam int SQR_WIDTH = 16;
    // mean of squares, squared mean and variance
    localparam int VAR_WIDTH = 16;
    // unsigned input scale position
    localparam int SHIFT_WIDTH = 5;

    // frame sequencing
    typedef enum logic [1:0] {
        ST_SETUP  = 2'b00,
        ST_INPUT  = 2'b01,
        ST_STATS  = 2'b10,
        ST_OUTPUT = 2'b11
    } ln_state_e;

endpackage

`default_nettype wire

// ==== hdl/ln_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module ln_ctrl_fsm import ln_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      in_data_num_vld,
    input  logic      input_done,
    input  logic      stats_done,
    input  logic      out_last_beat,
    output ln_state_e state
);

    ln_state_e next_state;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ST_SETUP;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            // wait for a frame length
            ST_SETUP: begin
                if (in_data_num_vld) begin
                    next_state = ST_INPUT;
                end
            end
            ST_INPUT: begin
                if (input_done) begin
                    next_state = ST_STATS;
                end
            end
            // accumulator drain and divider run here
            ST_STATS: begin
                if (stats_done) begin
                    next_state = ST_OUTPUT;
                end
            end
            // back to setup once the final beat is read
            ST_OUTPUT: begin
                if (out_last_beat) begin
                    next_state = ST_SETUP;
                end
            end
            default: begin
                next_state = ST_SETUP;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/ln_beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module ln_beat_counter import ln_pkg::*; #(
    parameter int DATA_NUM_WIDTH = 10,
    parameter int BUS_NUM        = 8
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  ln_state_e                 state,
    input  logic [DATA_NUM_WIDTH-1:0] in_data_num,
    input  logic                      in_data_num_vld,
    input  logic                      beat_vld,
    output logic                      input_done,
    output logic                      out_last_beat
);

    logic [DATA_NUM_WIDTH-1:0] beat_num;
    logic [DATA_NUM_WIDTH-1:0] beat_cnt;
    logic                      last_cnt;

    assign last_cnt      = (beat_cnt == beat_num - 1'b1);
    assign input_done    = beat_vld && (state == ST_INPUT) && last_cnt;
    assign out_last_beat = (state == ST_OUTPUT) && last_cnt;

    // beats per frame, length is taken only in setup
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_num <= '0;
        end else if (in_data_num_vld && state == ST_SETUP) begin
            beat_num <= in_data_num / DATA_NUM_WIDTH'(BUS_NUM);
        end
    end

    // input beats or readout beats, zero on every state change
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            beat_cnt <= '0;
        end else begin
            case (state)
                ST_INPUT: begin
                    if (input_done) begin
                        beat_cnt <= '0;
                    end else if (beat_vld) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                ST_OUTPUT: begin
                    if (out_last_beat) begin
                        beat_cnt <= '0;
                    end else begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                end
                default: begin
                    beat_cnt <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ln_lane_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module ln_lane_accum import ln_pkg::*; #(
    parameter int BUS_NUM     = 8,
    parameter int SUM_WIDTH   = 24,
    parameter int SQSUM_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  ln_state_e                     state,
    input  logic [BUS_NUM*LANE_WIDTH-1:0] in_data,
    input  logic                          beat_vld,
    input  logic                          input_done,
    output logic [SUM_WIDTH-1:0]          acc_sum,
    output logic [SQSUM_WIDTH-1:0]        acc_sqsum,
    output logic                          acc_done
);

    logic signed [SQR_WIDTH-1:0]  lane_ext [BUS_NUM];
    logic signed [LANE_WIDTH-1:0] smp_q [BUS_NUM];
    logic [SQR_WIDTH-1:0]         sqr_q [BUS_NUM];
    logic                         s1_vld;
    logic [SUM_WIDTH-1:0]         sum_c;
    logic [SQSUM_WIDTH-1:0]       sqsum_c;
    logic [SUM_WIDTH-1:0]         lane_sum;
    logic [SQSUM_WIDTH-1:0]       lane_sqsum;
    logic                         s2_vld;
    logic [2:0]                   done_dly;

    // sign extend so the square is formed at full width
    always_comb begin
        for (int i = 0; i < BUS_NUM; i++) begin
            lane_ext[i] = SQR_WIDTH'($signed(in_data[i*LANE_WIDTH +: LANE_WIDTH]));
        end
    end

    // stage 1, samples and squares
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_vld <= 1'b0;
            for (int i = 0; i < BUS_NUM; i++) begin
                smp_q[i] <= '0;
                sqr_q[i] <= '0;
            end
        end else begin
            s1_vld <= beat_vld;
            if (beat_vld) begin
                for (int i = 0; i < BUS_NUM; i++) begin
                    smp_q[i] <= lane_ext[i][LANE_WIDTH-1:0];
                    sqr_q[i] <= lane_ext[i] * lane_ext[i];
                end
            end
        end
    end

    always_comb begin
        sum_c   = '0;
        sqsum_c = '0;
        for (int i = 0; i < BUS_NUM; i++) begin
            sum_c   = sum_c + SUM_WIDTH'(smp_q[i]);
            sqsum_c = sqsum_c + SQSUM_WIDTH'(sqr_q[i]);
        end
    end

    // stage 2 lane sums, stage 3 frame accumulation
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lane_sum   <= '0;
            lane_sqsum <= '0;
            s2_vld     <= 1'b0;
            acc_sum    <= '0;
            acc_sqsum  <= '0;
            done_dly   <= '0;
        end else begin
            lane_sum   <= sum_c;
            lane_sqsum <= sqsum_c;
            s2_vld     <= s1_vld;
            done_dly   <= {done_dly[1:0], input_done};
            if (state == ST_SETUP) begin
                acc_sum   <= '0;
                acc_sqsum <= '0;
            end else if (s2_vld) begin
                acc_sum   <= acc_sum + lane_sum;
                acc_sqsum <= acc_sqsum + lane_sqsum;
            end
        end
    end

    assign acc_done = done_dly[2];

endmodule

`default_nettype wire

// ==== hdl/ln_stats_div.sv ====
`timescale 1ns/1ps
`default_nettype none

module ln_stats_div import ln_pkg::*; #(
    parameter int DATA_NUM_WIDTH = 10,
    parameter int SUM_WIDTH      = 24,
    parameter int SQSUM_WIDTH    = 32
) (
    input  logic                         clk,
    input  logic                         rstn,
    input  ln_state_e                    state,
    input  logic [DATA_NUM_WIDTH-1:0]    in_data_num,
    input  logic                         in_data_num_vld,
    input  logic [SHIFT_WIDTH-1:0]       in_scale_pos,
    input  logic                         in_scale_pos_vld,
    input  logic [SUM_WIDTH-1:0]         acc_sum,
    input  logic [SQSUM_WIDTH-1:0]       acc_sqsum,
    input  logic                         acc_done,
    output logic signed [LANE_WIDTH-1:0] mean,
    output logic [VAR_WIDTH-1:0]         variance,
    output logic                         stats_vld,
    output logic                         stats_done
);

    localparam int CNT_W = $clog2(SQSUM_WIDTH + 1);

    logic [DATA_NUM_WIDTH-1:0] data_num;
    logic [SHIFT_WIDTH-1:0]    scale_pos;
    logic [SUM_WIDTH-1:0]      sum_mag;
    logic                      sum_neg;
    logic                      busy;
    logic                      pass_sq;
    logic [CNT_W-1:0]          cnt;
    logic [DATA_NUM_WIDTH-1:0] rem;
    logic [SQSUM_WIDTH-1:0]    quo;
    logic [DATA_NUM_WIDTH:0]   rem_shift;
    logic                      rem_ge;
    logic [DATA_NUM_WIDTH-1:0] rem_next;
    logic [SQSUM_WIDTH-1:0]    quo_next;
    logic [VAR_WIDTH-1:0]      msq;
    logic [VAR_WIDTH-1:0]      msq_sh;
    logic [VAR_WIDTH-1:0]      sq_mean;
    logic                      var_p1;
    logic                      var_p2;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            data_num  <= '0;
            scale_pos <= '0;
        end else begin
            if (in_data_num_vld && state == ST_SETUP) begin
                data_num <= in_data_num;
            end
            if (in_scale_pos_vld) begin
                scale_pos <= in_scale_pos;
            end
        end
    end

    // divide magnitudes, the sign goes back on the quotient
    assign sum_mag = acc_sum[SUM_WIDTH-1] ? -acc_sum : acc_sum;

    // one restoring step per cycle, dividend bits shift out as quotient bits shift in
    assign rem_shift = {rem, quo[SQSUM_WIDTH-1]};
    assign rem_ge    = (rem_shift >= {1'b0, data_num});
    assign rem_next  = rem_ge ? DATA_NUM_WIDTH'(rem_shift - {1'b0, data_num})
                              : rem_shift[DATA_NUM_WIDTH-1:0];
    assign quo_next  = {quo[SQSUM_WIDTH-2:0], rem_ge};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy       <= 1'b0;
            pass_sq    <= 1'b0;
            cnt        <= '0;
            rem        <= '0;
            quo        <= '0;
            sum_neg    <= 1'b0;
            mean       <= '0;
            msq        <= '0;
            msq_sh     <= '0;
            sq_mean    <= '0;
            variance   <= '0;
            var_p1     <= 1'b0;
            var_p2     <= 1'b0;
            stats_vld  <= 1'b0;
            stats_done <= 1'b0;
        end else begin
            var_p1     <= 1'b0;
            var_p2     <= var_p1;
            stats_done <= var_p2;
            if (acc_done) begin
                // mean pass, sum left aligned in the shift register
                busy    <= 1'b1;
                pass_sq <= 1'b0;
                cnt     <= CNT_W'(SUM_WIDTH - 1);
                rem     <= '0;
                quo     <= {sum_mag, {(SQSUM_WIDTH - SUM_WIDTH){1'b0}}};
                sum_neg <= acc_sum[SUM_WIDTH-1];
            end else if (busy) begin
                rem <= rem_next;
                quo <= quo_next;
                cnt <= cnt - 1'b1;
                if (cnt == '0) begin
                    if (!pass_sq) begin
                        mean    <= sum_neg ? -quo_next[LANE_WIDTH-1:0]
                                           : quo_next[LANE_WIDTH-1:0];
                        pass_sq <= 1'b1;
                        cnt     <= CNT_W'(SQSUM_WIDTH - 1);
                        rem     <= '0;
                        quo     <= acc_sqsum;
                    end else begin
                        msq    <= quo_next[VAR_WIDTH-1:0];
                        busy   <= 1'b0;
                        var_p1 <= 1'b1;
                    end
                end
            end
            if (var_p1) begin
                msq_sh  <= msq >> scale_pos;
                sq_mean <= mean * mean;
            end
            if (var_p2) begin
                variance  <= msq_sh - sq_mean;
                stats_vld <= 1'b1;
            end else if (in_data_num_vld && state == ST_SETUP) begin
                stats_vld <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ln_frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ln_frame_buffer import ln_pkg::*; #(
    parameter int BUS_NUM   = 8,
    parameter int MAX_BEATS = 16
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  ln_state_e                     state,
    input  logic [BUS_NUM*LANE_WIDTH-1:0] in_data,
    input  logic                          beat_vld,
    input  logic signed [LANE_WIDTH-1:0]  mean,
    input  logic                          out_last_beat,
    output logic [BUS_NUM*LANE_WIDTH-1:0] out_data,
    output logic                          out_data_vld,
    output logic                          out_data_last
);

    localparam int PTR_W = (MAX_BEATS > 1) ? $clog2(MAX_BEATS) : 1;

    logic [BUS_NUM*LANE_WIDTH-1:0] mem [MAX_BEATS];
    logic [PTR_W-1:0]              wr_ptr;
    logic [PTR_W-1:0]              rd_ptr;
    logic                          rd_en;

    assign rd_en = (state == ST_OUTPUT);

    always_ff @(posedge clk) begin
        if (beat_vld) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // a frame always starts at entry zero
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (state == ST_SETUP) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (beat_vld) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // centred replay, each lane wraps in 8 bits
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_data      <= '0;
            out_data_vld  <= 1'b0;
            out_data_last <= 1'b0;
        end else begin
            out_data_vld  <= rd_en;
            out_data_last <= out_last_beat;
            for (int i = 0; i < BUS_NUM; i++) begin
                out_data[i*LANE_WIDTH +: LANE_WIDTH] <=
                    mem[rd_ptr][i*LANE_WIDTH +: LANE_WIDTH] - mean;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ln_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ln_top import ln_pkg::*; #(
    parameter int BUS_NUM        = 8,
    parameter int DATA_NUM_WIDTH = 10,
    parameter int MAX_BEATS      = 16,
    parameter int SUM_WIDTH      = 24,
    parameter int SQSUM_WIDTH    = 32
) (
    input  logic                          clk,
    input  logic                          rstn,
    input  logic [DATA_NUM_WIDTH-1:0]     in_data_num,
    input  logic                          in_data_num_vld,
    input  logic [SHIFT_WIDTH-1:0]        in_scale_pos,
    input  logic                          in_scale_pos_vld,
    input  logic [BUS_NUM*LANE_WIDTH-1:0] in_data,
    input  logic                          in_data_vld,
    output logic [BUS_NUM*LANE_WIDTH-1:0] out_data,
    output logic                          out_data_vld,
    output logic                          out_data_last,
    output logic [LANE_WIDTH-1:0]         out_mean,
    output logic [VAR_WIDTH-1:0]          out_var,
    output logic                          stats_vld
);

    ln_state_e                    state;
    logic                         beat_vld;
    logic                         input_done;
    logic                         out_last_beat;
    logic [SUM_WIDTH-1:0]         acc_sum;
    logic [SQSUM_WIDTH-1:0]       acc_sqsum;
    logic                         acc_done;
    logic signed [LANE_WIDTH-1:0] mean;
    logic                         stats_done;

    // beats outside the input state are dropped
    assign beat_vld = in_data_vld && (state == ST_INPUT);
    assign out_mean = mean;

    ln_ctrl_fsm u_ctrl_fsm (
        .clk             (clk),
        .rstn            (rstn),
        .in_data_num_vld (in_data_num_vld),
        .input_done      (input_done),
        .stats_done      (stats_done),
        .out_last_beat   (out_last_beat),
        .state           (state)
    );

    ln_beat_counter #(
        .DATA_NUM_WIDTH (DATA_NUM_WIDTH),
        .BUS_NUM        (BUS_NUM)
    ) u_beat_counter (
        .clk             (clk),
        .rstn            (rstn),
        .state           (state),
        .in_data_num     (in_data_num),
        .in_data_num_vld (in_data_num_vld),
        .beat_vld        (beat_vld),
        .input_done      (input_done),
        .out_last_beat   (out_last_beat)
    );

    ln_lane_accum #(
        .BUS_NUM     (BUS_NUM),
        .SUM_WIDTH   (SUM_WIDTH),
        .SQSUM_WIDTH (SQSUM_WIDTH)
    ) u_lane_accum (
        .clk        (clk),
        .rstn       (rstn),
        .state      (state),
        .in_data    (in_data),
        .beat_vld   (beat_vld),
        .input_done (input_done),
        .acc_sum    (acc_sum),
        .acc_sqsum  (acc_sqsum),
        .acc_done   (acc_done)
    );

    ln_stats_div #(
        .DATA_NUM_WIDTH (DATA_NUM_WIDTH),
        .SUM_WIDTH      (SUM_WIDTH),
        .SQSUM_WIDTH    (SQSUM_WIDTH)
    ) u_stats_div (
        .clk              (clk),
        .rstn             (rstn),
        .state            (state),
        .in_data_num      (in_data_num),
        .in_data_num_vld  (in_data_num_vld),
        .in_scale_pos     (in_scale_pos),
        .in_scale_pos_vld (in_scale_pos_vld),
        .acc_sum          (acc_sum),
        .acc_sqsum        (acc_sqsum),
        .acc_done         (acc_done),
        .mean             (mean),
        .variance         (out_var),
        .stats_vld        (stats_vld),
        .stats_done       (stats_done)
    );

    ln_frame_buffer #(
        .BUS_NUM   (BUS_NUM),
        .MAX_BEATS (MAX_BEATS)
    ) u_frame_buffer (
        .clk           (clk),
        .rstn          (rstn),
        .state         (state),
        .in_data       (in_data),
        .beat_vld      (beat_vld),
        .mean          (mean),
        .out_last_beat (out_last_beat),
        .out_data      (out_data),
        .out_data_vld  (out_data_vld),
        .out_data_last (out_data_last)
    );

endmodule

`default_nettype wire

// ==== dv/ln_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module ln_asserts import ln_pkg::*; #(
    parameter int BUS_NUM        = 8,
    parameter int DATA_NUM_WIDTH = 10
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  ln_state_e                 state,
    input  logic [DATA_NUM_WIDTH-1:0] in_data_num,
    input  logic                      in_data_num_vld,
    input  logic                      out_data_vld,
    input  logic                      out_data_last,
    input  logic                      stats_vld
);

    logic [DATA_NUM_WIDTH-1:0] exp_beats;
    logic [DATA_NUM_WIDTH-1:0] out_cnt;
    // number of failed properties so far
    int                        fail_cnt = 0;

    // beats per frame as taken in setup
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            exp_beats <= '0;
        end else if (in_data_num_vld && state == ST_SETUP) begin
            exp_beats <= in_data_num / DATA_NUM_WIDTH'(BUS_NUM);
        end
    end

    // output beats seen so far in this frame
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_cnt <= '0;
        end else if (out_data_last) begin
            out_cnt <= '0;
        end else if (out_data_vld) begin
            out_cnt <= out_cnt + 1'b1;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        !rstn |-> !out_data_vld && !out_data_last && !stats_vld)
        else begin
            $error("output flags active during reset");
            fail_cnt = fail_cnt + 1;
        end

    reset_exit: assert property (@(posedge clk)
        $rose(rstn) |-> !out_data_vld && !out_data_last && !stats_vld)
        else begin
            $error("output flags active right after reset");
            fail_cnt = fail_cnt + 1;
        end

    out_after_stats: assert property (@(posedge clk) disable iff (!rstn)
        out_data_vld |-> stats_vld)
        else begin
            $error("output beat while statistics are not valid");
            fail_cnt = fail_cnt + 1;
        end

    last_with_vld: assert property (@(posedge clk) disable iff (!rstn)
        out_data_last |-> out_data_vld)
        else begin
            $error("last flag without a valid beat");
            fail_cnt = fail_cnt + 1;
        end

    back_to_back: assert property (@(posedge clk) disable iff (!rstn)
        out_data_vld && !out_data_last |=> out_data_vld)
        else begin
            $error("gap between output beats");
            fail_cnt = fail_cnt + 1;
        end

    // last flag exactly on the final beat of the configured count
    last_on_final: assert property (@(posedge clk) disable iff (!rstn)
        out_data_vld |-> (out_data_last == (out_cnt == exp_beats - 1'b1)))
        else begin
            $error("output beat count does not match the frame length");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind ln_top ln_asserts #(
    .BUS_NUM        (BUS_NUM),
    .DATA_NUM_WIDTH (DATA_NUM_WIDTH)
) u_ln_asserts (
    .clk             (clk),
    .rstn            (rstn),
    .state           (state),
    .in_data_num     (in_data_num),
    .in_data_num_vld (in_data_num_vld),
    .out_data_vld    (out_data_vld),
    .out_data_last   (out_data_last),
    .stats_vld       (stats_vld)
);

`default_nettype wire

// ==== dv/ln_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ln_tb import ln_pkg::*;;

    localparam int BUS_NUM        = 8;
    localparam int DATA_NUM_WIDTH = 10;
    localparam int MAX_BEATS      = 16;
    localparam int SUM_WIDTH      = 24;
    localparam int SQSUM_WIDTH    = 32;
    localparam int BEAT_W         = BUS_NUM * LANE_WIDTH;
    localparam int RST_CYCLES     = 5;
    localparam int MAX_GAP        = 2;
    localparam int NUM_TESTS      = 6;
    // per test: beats, scale in force, scale written, negative bias, stray strobes
    localparam int TEST_BEATS [NUM_TESTS]    = '{1, 4, 16, 8, 16, 4};
    localparam int TEST_SCALE [NUM_TESTS]    = '{0, 0, 0, 3, 3, 3};
    localparam bit TEST_WR_SCALE [NUM_TESTS] = '{1, 0, 0, 1, 0, 0};
    localparam bit TEST_NEG [NUM_TESTS]      = '{0, 0, 0, 0, 1, 1};
    localparam bit TEST_NOISE [NUM_TESTS]    = '{0, 0, 1, 0, 0, 1};

    logic                      clk;
    logic                      rstn;
    logic [DATA_NUM_WIDTH-1:0] in_data_num;
    logic                      in_data_num_vld;
    logic [SHIFT_WIDTH-1:0]    in_scale_pos;
    logic                      in_scale_pos_vld;
    logic [BEAT_W-1:0]         in_data;
    logic                      in_data_vld;
    logic [BEAT_W-1:0]         out_data;
    logic                      out_data_vld;
    logic                      out_data_last;
    logic [LANE_WIDTH-1:0]     out_mean;
    logic [VAR_WIDTH-1:0]      out_var;
    logic                      stats_vld;
    logic [BEAT_W-1:0]         sent [$];
    int                        cycles = 0;
    int                        test_errors;
    int                        total_errors;
    int                        tests_failed;

    ln_top #(
        .BUS_NUM        (BUS_NUM),
        .DATA_NUM_WIDTH (DATA_NUM_WIDTH),
        .MAX_BEATS      (MAX_BEATS),
        .SUM_WIDTH      (SUM_WIDTH),
        .SQSUM_WIDTH    (SQSUM_WIDTH)
    ) u_ln_top (
        .clk              (clk),
        .rstn             (rstn),
        .in_data_num      (in_data_num),
        .in_data_num_vld  (in_data_num_vld),
        .in_scale_pos     (in_scale_pos),
        .in_scale_pos_vld (in_scale_pos_vld),
        .in_data          (in_data),
        .in_data_vld      (in_data_vld),
        .out_data         (out_data),
        .out_data_vld     (out_data_vld),
        .out_data_last    (out_data_last),
        .out_mean         (out_mean),
        .out_var          (out_var),
        .stats_vld        (stats_vld)
    );

    always #20 clk = ~clk;

    // input with gaps, divider passes, replay, then slack
    function automatic int cycle_limit();
        int total;
        total = RST_CYCLES + 10;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += TEST_BEATS[t] * (MAX_GAP + 2) + SUM_WIDTH + SQSUM_WIDTH + 20;
        end
        return total;
    endfunction

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit()) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit());
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [BEAT_W-1:0] draw_beat(input bit neg);
        logic [BEAT_W-1:0] beat;
        int                s;
        for (int l = 0; l < BUS_NUM; l++) begin
            // negative bias keeps samples in -128..40
            s = int'($urandom_range(neg ? 168 : 255, 0)) - 128;
            beat[l*LANE_WIDTH +: LANE_WIDTH] = LANE_WIDTH'(s);
        end
        return beat;
    endfunction

    // reference statistics over the frame in sent
    function automatic void expected_stats(input int scale, output logic [LANE_WIDTH-1:0] m,
                                           output logic [VAR_WIDTH-1:0] v);
        int                   sum;
        int                   sqsum;
        int                   s;
        int                   n;
        int                   q;
        int                   mean_i;
        logic [VAR_WIDTH-1:0] msq;
        sum   = 0;
        sqsum = 0;
        n     = sent.size() * BUS_NUM;
        foreach (sent[b]) begin
            for (int l = 0; l < BUS_NUM; l++) begin
                s = int'($signed(sent[b][l*LANE_WIDTH +: LANE_WIDTH]));
                sum += s;
                sqsum += s * s;
            end
        end
        // magnitude divide truncates toward zero
        q      = ((sum < 0) ? -sum : sum) / n;
        mean_i = (sum < 0) ? -q : q;
        msq    = VAR_WIDTH'(sqsum / n);
        m      = LANE_WIDTH'(mean_i);
        v      = VAR_WIDTH'(int'(msq >> scale) - mean_i * mean_i);
    endfunction

    function automatic logic [BEAT_W-1:0] centre_beat(input logic [BEAT_W-1:0] beat,
                                                      input logic [LANE_WIDTH-1:0] m);
        logic [BEAT_W-1:0] res;
        for (int l = 0; l < BUS_NUM; l++) begin
            res[l*LANE_WIDTH +: LANE_WIDTH] = beat[l*LANE_WIDTH +: LANE_WIDTH] - m;
        end
        return res;
    endfunction

    task automatic run_frame(input int idx);
        int                    beats;
        int                    gap;
        int                    got;
        logic [LANE_WIDTH-1:0] exp_mean;
        logic [VAR_WIDTH-1:0]  exp_var;
        logic [BEAT_W-1:0]     exp_beat;
        beats       = TEST_BEATS[idx];
        test_errors = 0;
        sent.delete();
        in_data_num      = DATA_NUM_WIDTH'(beats * BUS_NUM);
        in_data_num_vld  = 1'b1;
        in_scale_pos     = SHIFT_WIDTH'(TEST_SCALE[idx]);
        in_scale_pos_vld = TEST_WR_SCALE[idx];
        @(negedge clk);
        in_data_num_vld  = 1'b0;
        in_scale_pos_vld = 1'b0;
        // the held position must not follow the bus without a strobe
        in_scale_pos     = '1;
        for (int b = 0; b < beats; b++) begin
            gap = $urandom_range(MAX_GAP, 0);
            for (int g = 0; g < gap; g++) begin
                // a new length mid-frame has to be ignored
                in_data_vld     = 1'b0;
                in_data_num     = DATA_NUM_WIDTH'(BUS_NUM);
                in_data_num_vld = TEST_NOISE[idx];
                @(negedge clk);
            end
            in_data_num_vld = 1'b0;
            in_data         = draw_beat(TEST_NEG[idx]);
            in_data_vld     = 1'b1;
            sent.push_back(in_data);
            @(negedge clk);
        end
        expected_stats(TEST_SCALE[idx], exp_mean, exp_var);
        // stray beats during statistics
        while (!stats_vld) begin
            in_data_vld = TEST_NOISE[idx];
            in_data     = draw_beat(1'b0);
            @(negedge clk);
        end
        assert (out_mean == exp_mean) else begin
            $display("Fail at %0t: mean %0d, expected %0d", $time,
                     $signed(out_mean), $signed(exp_mean));
            test_errors++;
        end
        assert (out_var == exp_var) else begin
            $display("Fail at %0t: variance %0d, expected %0d", $time, out_var, exp_var);
            test_errors++;
        end
        got = 0;
        while (got < beats) begin
            if (out_data_vld) begin
                exp_beat = centre_beat(sent[got], exp_mean);
                assert (out_data == exp_beat) else begin
                    $display("Fail at %0t: beat %0d is %h, expected %h", $time, got,
                             out_data, exp_beat);
                    test_errors++;
                end
                got++;
            end
            in_data_vld = TEST_NOISE[idx];
            in_data     = draw_beat(1'b0);
            @(negedge clk);
        end
        in_data_vld = 1'b0;
        $display("test %0d: %0d beats, scale %0d, %0d errors", idx, beats,
                 TEST_SCALE[idx], test_errors);
        total_errors += test_errors;
        if (test_errors != 0) begin
            tests_failed++;
        end
    endtask

    initial begin
        void'($urandom(32'hb35c_3c8b));
        clk              = 1'b0;
        rstn             = 1'b1;
        in_data_num      = '0;
        in_data_num_vld  = 1'b0;
        in_scale_pos     = '0;
        in_scale_pos_vld = 1'b0;
        in_data          = '0;
        in_data_vld      = 1'b0;
        total_errors     = 0;
        tests_failed     = 0;
        // falling edge on rstn for the asynchronous reset
        #1;
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_frame(t);
        end
        // protocol properties that failed anywhere in the run
        total_errors += u_ln_top.u_ln_asserts.fail_cnt;
        $display("%0d tests run, %0d failed, %0d checks failed", NUM_TESTS,
                 tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/ln_pkg.sv
hdl/ln_ctrl_fsm.sv
hdl/ln_beat_counter.sv
hdl/ln_lane_accum.sv
hdl/ln_stats_div.sv
hdl/ln_frame_buffer.sv
hdl/ln_top.sv
dv/ln_asserts.sv
dv/ln_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module ln_tb -Mdir obj_dir -f list.f \
    && ./obj_dir/Vln_tb | tee /dev/stderr | grep -qx "TEST RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
